// File: logic/sfm_pkg.sv
`default_nettype none

package sfm_pkg;

    localparam int unsigned ELEM_W = 16;
    // Weight of 1.0 is 2^FRAC_W
    localparam int unsigned FRAC_W = 15;
    localparam int unsigned DEN_W  = 24;
    localparam int unsigned ADDR_W = 8;
    localparam int unsigned LEN_W  = 8;

    typedef enum logic [1:0] {
        MODE_FULL,
        MODE_ACC_ONLY,
        MODE_DIV_ONLY
    } sfm_mode_e;

    typedef struct packed {
        sfm_mode_e          mode;
        logic               last;
        logic [3:0]         slot;
        logic [ADDR_W-1:0]  base;
        logic [LEN_W-1:0]   len;
    } sfm_cmd_t;

    typedef struct packed {
        logic               valid;
        logic [ELEM_W-1:0]  max;
        logic [DEN_W-1:0]   den;
    } sfm_slot_t;

    typedef struct packed {
        logic               dividing;
        logic               clear_regs;
        logic               load_slot;
        logic [ELEM_W-1:0]  slot_max;
        logic [DEN_W-1:0]   slot_den;
        logic               pass_end;
    } sfm_dp_ctrl_t;

    typedef struct packed {
        logic               busy;
        logic [ELEM_W-1:0]  max;
        logic [DEN_W-1:0]   den;
    } sfm_dp_flags_t;

endpackage

`default_nettype wire

// File: logic/sfm_serial_div.sv
`default_nettype none

module sfm_serial_div (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        start_i,
    input  logic [sfm_pkg::ELEM_W+sfm_pkg::FRAC_W-1:0]  dividend_i,
    input  logic [sfm_pkg::DEN_W-1:0]                   divisor_i,
    output logic                                        done_o,
    output logic [sfm_pkg::ELEM_W-1:0]                  quotient_o
);

    localparam int unsigned ELEM_W = sfm_pkg::ELEM_W;
    localparam int unsigned DEN_W  = sfm_pkg::DEN_W;
    localparam int unsigned DIVD_W = ELEM_W + sfm_pkg::FRAC_W;

    logic               busy_q, done_q;
    logic [4:0]         steps_q;
    logic [DEN_W-1:0]   rem_q, divisor_q;
    logic [DIVD_W-1:0]  acc_q;
    logic [DEN_W-1:0]   rem_in, divisor_in, rem_nxt;
    logic [DIVD_W-1:0]  acc_in;
    logic [DEN_W:0]     shifted;
    logic [DEN_W+1:0]   trial;

    // The first step runs in the start cycle straight from the inputs
    assign rem_in     = start_i ? '0 : rem_q;
    assign acc_in     = start_i ? dividend_i : acc_q;
    assign divisor_in = start_i ? divisor_i : divisor_q;

    assign shifted = {rem_in, acc_in[DIVD_W-1]};
    assign trial   = {1'b0, shifted} - {2'b00, divisor_in};
    assign rem_nxt = trial[DEN_W+1] ? shifted[DEN_W-1:0] : trial[DEN_W-1:0];

    assign done_o     = done_q;
    assign quotient_o = (|acc_q[DIVD_W-1:ELEM_W]) ? '1 : acc_q[ELEM_W-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            steps_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q  <= 1'b1;
                steps_q <= 5'(DIVD_W - 1);
            end else if (busy_q) begin
                steps_q <= steps_q - 1'b1;
                if (steps_q == 5'd1) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i || busy_q) begin
            rem_q     <= rem_nxt;
            acc_q     <= {acc_in[DIVD_W-2:0], ~trial[DEN_W+1]};
            divisor_q <= divisor_in;
        end
    end

endmodule

`default_nettype wire

// File: logic/sfm_ctrl.sv
`default_nettype none

module sfm_ctrl #(
    parameter int unsigned N_SLOTS = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  sfm_pkg::sfm_cmd_t           cmd_i,
    input  logic                        cmd_valid_i,
    input  logic                        fetch_done_i,
    input  sfm_pkg::sfm_dp_flags_t      dp_flags_i,
    input  logic                        div_idle_i,
    output logic                        cmd_ready_o,
    output logic                        done_o,
    output logic                        pass_start_o,
    output logic [sfm_pkg::ADDR_W-1:0]  base_o,
    output logic [sfm_pkg::LEN_W-1:0]   len_o,
    output sfm_pkg::sfm_dp_ctrl_t       dp_ctrl_o
);

    localparam int unsigned SLOT_IW = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1;

    typedef enum logic [2:0] {
        IDLE,
        ACCUMULATE,
        WAIT_EMPTY,
        NORMALIZE,
        FINISHED
    } state_e;

    state_e                             state_q, state_d;
    sfm_pkg::sfm_cmd_t                  cmd_q;
    sfm_pkg::sfm_slot_t [N_SLOTS-1:0]   slot_q;
    logic                               norm_q, norm_d;
    logic                               pass_start_q, pass_start_d;
    logic [SLOT_IW-1:0]                 new_slot, cur_slot;
    logic                               accept;
    logic                               slot_wr, slot_clr;

    assign accept   = cmd_valid_i & cmd_ready_o;
    assign new_slot = cmd_i.slot[SLOT_IW-1:0];
    assign cur_slot = cmd_q.slot[SLOT_IW-1:0];

    assign pass_start_o = pass_start_q;
    assign base_o       = cmd_q.base;
    assign len_o        = cmd_q.len;

    always_comb begin
        state_d      = state_q;
        norm_d       = norm_q;
        pass_start_d = 1'b0;
        slot_wr      = 1'b0;
        slot_clr     = 1'b0;
        cmd_ready_o  = 1'b0;
        done_o       = 1'b0;

        dp_ctrl_o          = '0;
        dp_ctrl_o.dividing = norm_q;
        dp_ctrl_o.slot_max = slot_q[new_slot].max;
        dp_ctrl_o.slot_den = slot_q[new_slot].den;

        case (state_q)
            IDLE: begin
                cmd_ready_o = 1'b1;
                if (cmd_valid_i) begin
                    // Resume from the saved state of an earlier chunk
                    dp_ctrl_o.load_slot = slot_q[new_slot].valid;
                    pass_start_d        = 1'b1;
                    if (cmd_i.mode == sfm_pkg::MODE_DIV_ONLY) begin
                        norm_d  = 1'b1;
                        state_d = NORMALIZE;
                    end else begin
                        state_d = ACCUMULATE;
                    end
                end
            end

            ACCUMULATE, NORMALIZE: begin
                if (fetch_done_i) begin
                    state_d = WAIT_EMPTY;
                end
            end

            WAIT_EMPTY: begin
                dp_ctrl_o.pass_end = 1'b1;
                if (!dp_flags_i.busy && div_idle_i) begin
                    if (norm_q || cmd_q.mode == sfm_pkg::MODE_ACC_ONLY) begin
                        state_d = FINISHED;
                    end else begin
                        norm_d       = 1'b1;
                        pass_start_d = 1'b1;
                        state_d      = NORMALIZE;
                    end
                end
            end

            FINISHED: begin
                done_o               = 1'b1;
                dp_ctrl_o.clear_regs = 1'b1;
                norm_d               = 1'b0;
                slot_wr  = (cmd_q.mode == sfm_pkg::MODE_ACC_ONLY);
                slot_clr = (cmd_q.mode == sfm_pkg::MODE_DIV_ONLY) && cmd_q.last;
                state_d  = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            norm_q       <= 1'b0;
            pass_start_q <= 1'b0;
            slot_q       <= '0;
        end else begin
            state_q      <= state_d;
            norm_q       <= norm_d;
            pass_start_q <= pass_start_d;
            if (slot_wr) begin
                slot_q[cur_slot] <= '{valid: 1'b1, max: dp_flags_i.max, den: dp_flags_i.den};
            end else if (slot_clr) begin
                slot_q[cur_slot] <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q <= cmd_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/sfm_fetch.sv
`default_nettype none

module sfm_fetch #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        pass_start_i,
    input  logic [sfm_pkg::ADDR_W-1:0]  base_i,
    input  logic [sfm_pkg::LEN_W-1:0]   len_i,
    input  logic [sfm_pkg::ELEM_W-1:0]  mem_rdata_i,
    input  logic                        credit_i,
    output logic                        mem_req_o,
    output logic [sfm_pkg::ADDR_W-1:0]  mem_addr_o,
    output logic                        push_o,
    output logic [sfm_pkg::ELEM_W-1:0]  push_data_o,
    output logic                        fetch_done_o
);

    localparam int unsigned CRED_W = $clog2(FIFO_DEPTH + 1);

    logic                       active_q, push_q, done_q;
    logic [sfm_pkg::ADDR_W-1:0] addr_q;
    logic [sfm_pkg::LEN_W-1:0]  left_q;
    logic [CRED_W-1:0]          credits_q;
    logic                       req, last_req;

    // One credit per free FIFO entry
    assign req      = active_q && (credits_q != '0);
    assign last_req = req && (left_q == sfm_pkg::LEN_W'(1));

    assign mem_req_o    = req;
    assign mem_addr_o   = addr_q;
    assign push_o       = push_q;
    assign push_data_o  = mem_rdata_i;
    assign fetch_done_o = done_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q  <= 1'b0;
            push_q    <= 1'b0;
            done_q    <= 1'b0;
            credits_q <= CRED_W'(FIFO_DEPTH);
        end else begin
            push_q <= req;
            done_q <= last_req;
            if (pass_start_i) begin
                active_q <= 1'b1;
            end else if (last_req) begin
                active_q <= 1'b0;
            end
            case ({credit_i, req})
                2'b10:   credits_q <= credits_q + 1'b1;
                2'b01:   credits_q <= credits_q - 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (pass_start_i) begin
            addr_q <= base_i;
            left_q <= len_i;
        end else if (req) begin
            addr_q <= addr_q + 1'b1;
            left_q <= left_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/sfm_credit_fifo.sv
`default_nettype none

module sfm_credit_fifo #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        push_i,
    input  logic [sfm_pkg::ELEM_W-1:0]  push_data_i,
    input  logic                        pop_i,
    output logic [sfm_pkg::ELEM_W-1:0]  head_o,
    output logic                        not_empty_o,
    output logic                        credit_o
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [sfm_pkg::ELEM_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]           count_q;
    logic                       credit_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_o      = mem_q[rd_ptr_q];
    assign not_empty_o = (count_q != '0);
    assign credit_o    = credit_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            // The producer never pushes without credit
            credit_q <= pop_i;
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/sfm_datapath.sv
`default_nettype none

module sfm_datapath (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  sfm_pkg::sfm_dp_ctrl_t       dp_ctrl_i,
    input  logic [sfm_pkg::ELEM_W-1:0]  head_i,
    input  logic                        not_empty_i,
    output logic                        pop_o,
    output sfm_pkg::sfm_dp_flags_t      dp_flags_o,
    output logic                        res_valid_o,
    output logic [sfm_pkg::ELEM_W-1:0]  res_o
);

    localparam int unsigned ELEM_W = sfm_pkg::ELEM_W;
    localparam int unsigned DEN_W  = sfm_pkg::DEN_W;
    localparam logic [ELEM_W-1:0] W_ONE   = ELEM_W'(1) << sfm_pkg::FRAC_W;
    localparam logic [DEN_W-1:0]  DEN_ONE = DEN_W'(1) << sfm_pkg::FRAC_W;

    logic [ELEM_W-1:0]  max_q;
    logic [DEN_W-1:0]   den_q;
    logic               has_max_q, wait_q, res_valid_q;
    logic [ELEM_W-1:0]  res_q;
    logic [ELEM_W:0]    below, above;
    logic               x_gt_max;
    logic [4:0]         rescale;
    logic [ELEM_W-1:0]  weight;
    logic               div_start, div_done;
    logic [ELEM_W-1:0]  quotient;

    assign below    = {max_q[ELEM_W-1], max_q} - {head_i[ELEM_W-1], head_i};
    assign above    = {head_i[ELEM_W-1], head_i} - {max_q[ELEM_W-1], max_q};
    assign x_gt_max = $signed(head_i) > $signed(max_q);
    assign rescale  = (above > 31) ? 5'd31 : above[4:0];
    // Shifts of 16 or more leave nothing
    assign weight   = W_ONE >> below;

    // One element at a time while a division is running
    assign pop_o     = not_empty_i && !wait_q;
    assign div_start = pop_o && dp_ctrl_i.dividing;

    assign dp_flags_o.busy = !dp_ctrl_i.pass_end || not_empty_i || wait_q;
    assign dp_flags_o.max  = max_q;
    assign dp_flags_o.den  = den_q;
    assign res_valid_o     = res_valid_q;
    assign res_o           = res_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            has_max_q   <= 1'b0;
            max_q       <= '0;
            den_q       <= '0;
            wait_q      <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= div_done;
            if (div_start) begin
                wait_q <= 1'b1;
            end else if (div_done) begin
                wait_q <= 1'b0;
            end
            if (dp_ctrl_i.clear_regs) begin
                has_max_q <= 1'b0;
                max_q     <= '0;
                den_q     <= '0;
            end else if (dp_ctrl_i.load_slot) begin
                has_max_q <= 1'b1;
                max_q     <= dp_ctrl_i.slot_max;
                den_q     <= dp_ctrl_i.slot_den;
            end else if (pop_o && !dp_ctrl_i.dividing) begin
                has_max_q <= 1'b1;
                if (!has_max_q) begin
                    max_q <= head_i;
                    den_q <= DEN_ONE;
                end else if (x_gt_max) begin
                    // Rescale the sum to the new max first
                    max_q <= head_i;
                    den_q <= (den_q >> rescale) + DEN_ONE;
                end else begin
                    den_q <= den_q + DEN_W'(weight);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (div_done) begin
            res_q <= quotient;
        end
    end

    sfm_serial_div i_div (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (div_start),
        .dividend_i ({weight, {sfm_pkg::FRAC_W{1'b0}}}),
        .divisor_i  (den_q),
        .done_o     (div_done),
        .quotient_o (quotient)
    );

endmodule

`default_nettype wire

// File: logic/sfm_top.sv
`default_nettype none

module sfm_top #(
    parameter int unsigned N_SLOTS    = 4,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  sfm_pkg::sfm_cmd_t           cmd_i,
    input  logic                        cmd_valid_i,
    output logic                        cmd_ready_o,
    output logic                        done_o,
    output logic                        mem_req_o,
    output logic [sfm_pkg::ADDR_W-1:0]  mem_addr_o,
    input  logic [sfm_pkg::ELEM_W-1:0]  mem_rdata_i,
    output logic                        res_valid_o,
    output logic [sfm_pkg::ELEM_W-1:0]  res_o
);

    logic                       pass_start, fetch_done;
    logic [sfm_pkg::ADDR_W-1:0] base;
    logic [sfm_pkg::LEN_W-1:0]  len;
    logic                       push, pop, not_empty, credit;
    logic [sfm_pkg::ELEM_W-1:0] push_data, head;
    sfm_pkg::sfm_dp_ctrl_t      dp_ctrl;
    sfm_pkg::sfm_dp_flags_t     dp_flags;

    sfm_ctrl #(
        .N_SLOTS (N_SLOTS)
    ) i_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .fetch_done_i (fetch_done),
        .dp_flags_i   (dp_flags),
        // Last quotient still on its way out
        .div_idle_i   (!res_valid_o),
        .cmd_ready_o  (cmd_ready_o),
        .done_o       (done_o),
        .pass_start_o (pass_start),
        .base_o       (base),
        .len_o        (len),
        .dp_ctrl_o    (dp_ctrl)
    );

    sfm_fetch #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fetch (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pass_start_i (pass_start),
        .base_i       (base),
        .len_i        (len),
        .mem_rdata_i  (mem_rdata_i),
        .credit_i     (credit),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .fetch_done_o (fetch_done)
    );

    sfm_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .credit_o    (credit)
    );

    sfm_datapath i_datapath (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .dp_ctrl_i   (dp_ctrl),
        .head_i      (head),
        .not_empty_i (not_empty),
        .pop_o       (pop),
        .dp_flags_o  (dp_flags),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

`default_nettype wire

// File: verif/sfm_tb.sv
`default_nettype none

module sfm_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned N_TESTS   = 8;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        sfm_pkg::sfm_mode_e mode;
        logic               last;
        logic [3:0]         slot;
        logic [7:0]         base;
        logic [7:0]         len;
        logic [7:0]         n_res;
    } test_row_t;

    // Rows 1 to 4 split one 16-element vector over slot 1
    test_row_t tests [N_TESTS] = '{
        '{sfm_pkg::MODE_FULL,     1'b0, 4'd0, 8'h10, 8'd12, 8'd12},
        '{sfm_pkg::MODE_ACC_ONLY, 1'b0, 4'd1, 8'h40, 8'd8,  8'd0},
        '{sfm_pkg::MODE_ACC_ONLY, 1'b0, 4'd1, 8'h48, 8'd8,  8'd0},
        '{sfm_pkg::MODE_DIV_ONLY, 1'b0, 4'd1, 8'h40, 8'd8,  8'd8},
        '{sfm_pkg::MODE_DIV_ONLY, 1'b1, 4'd1, 8'h48, 8'd8,  8'd8},
        '{sfm_pkg::MODE_FULL,     1'b0, 4'd1, 8'h80, 8'd10, 8'd10},
        '{sfm_pkg::MODE_FULL,     1'b0, 4'd2, 8'hfc, 8'd6,  8'd6},
        '{sfm_pkg::MODE_FULL,     1'b0, 4'd3, 8'h33, 8'd1,  8'd1}
    };

    logic                       clk_i = 1'b0;
    logic                       rst_ni;
    sfm_pkg::sfm_cmd_t          cmd_i;
    logic                       cmd_valid_i;
    logic                       cmd_ready_o, done_o;
    logic                       mem_req_o;
    logic [sfm_pkg::ADDR_W-1:0] mem_addr_o;
    logic [sfm_pkg::ELEM_W-1:0] mem_rdata_i;
    logic                       res_valid_o;
    logic [sfm_pkg::ELEM_W-1:0] res_o;

    logic [15:0]    mem [256];
    logic           rd_pending = 1'b0;
    logic [7:0]     rd_addr;
    logic [31:0]    lfsr_q = 32'hbbb3;
    logic [15:0]    exp_q [$];
    logic           m_valid [16];
    int             m_max [16];
    int             m_den [16];

    int unsigned    cycles = 0;
    int unsigned    cycle_limit = 1000;
    int unsigned    errors = 0;
    int unsigned    tests_failed = 0;
    int unsigned    req_cnt, done_cnt, res_idx;
    logic           busy_cmd = 1'b0;
    logic           after_done = 1'b0;
    logic           cmd_accepted, row_done;
    logic [7:0]     cur_base, cur_len, exp_addr;

    always #50 clk_i = ~clk_i;

    sfm_top #(
        .N_SLOTS    (4),
        .FIFO_DEPTH (2)
    ) dut0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .done_o      (done_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_rdata_i (mem_rdata_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int unsigned v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v      = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Power-of-two stand-in for exp(x - max)
    function automatic int weight_of(input int diff);
        if (diff >= 16) begin
            return 0;
        end
        return 32768 >> diff;
    endfunction

    function automatic string mode_name(input sfm_pkg::sfm_mode_e m);
        case (m)
            sfm_pkg::MODE_FULL:     return "full";
            sfm_pkg::MODE_ACC_ONLY: return "acc";
            default:                return "div";
        endcase
    endfunction

    task automatic run_model(input test_row_t row);
        int     k, x, mx, den, sh;
        logic   has;
        exp_q.delete();
        has = m_valid[row.slot];
        mx  = m_max[row.slot];
        den = m_den[row.slot];
        if (row.mode != sfm_pkg::MODE_DIV_ONLY) begin
            for (k = 0; k < row.len; k++) begin
                x = int'($signed(mem[8'(row.base + k)]));
                if (!has) begin
                    mx  = x;
                    den = 32768;
                    has = 1'b1;
                end else if (x > mx) begin
                    sh  = (x - mx > 31) ? 31 : x - mx;
                    den = (den >> sh) + 32768;
                    mx  = x;
                end else begin
                    den = den + weight_of(mx - x);
                end
            end
        end
        if (row.mode != sfm_pkg::MODE_ACC_ONLY) begin
            for (k = 0; k < row.len; k++) begin
                x = int'($signed(mem[8'(row.base + k)]));
                exp_q.push_back(16'((longint'(weight_of(mx - x)) << 15) / den));
            end
        end
        if (row.mode == sfm_pkg::MODE_ACC_ONLY) begin
            m_valid[row.slot] = 1'b1;
            m_max[row.slot]   = mx;
            m_den[row.slot]   = den;
        end else if (row.mode == sfm_pkg::MODE_DIV_ONLY && row.last) begin
            m_valid[row.slot] = 1'b0;
            m_max[row.slot]   = 0;
            m_den[row.slot]   = 0;
        end
    endtask

    // Memory answers one cycle after the request
    always @(posedge clk_i) begin
        rd_pending <= mem_req_o;
        rd_addr    <= mem_addr_o;
    end

    always @(negedge clk_i) begin
        if (rd_pending) begin
            mem_rdata_i = mem[rd_addr];
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (mem_req_o) begin
                exp_addr = (cur_len != 0) ? cur_base + 8'(req_cnt % cur_len) : cur_base;
                assert (mem_addr_o == exp_addr) else begin
                    $display("** Error at %0t: mem_addr_o = %h, expected %h",
                             $time, mem_addr_o, exp_addr);
                    errors++;
                end
                req_cnt++;
            end
            if (res_valid_o) begin
                if (res_idx < exp_q.size()) begin
                    assert (res_o == exp_q[res_idx]) else begin
                        $display("** Error at %0t: res_o = %h, expected %h",
                                 $time, res_o, exp_q[res_idx]);
                        errors++;
                    end
                end
                res_idx++;
            end
            if (done_o) begin
                done_cnt++;
            end
            if (busy_cmd) begin
                if (after_done) begin
                    assert (cmd_ready_o) else begin
                        $display("** Error at %0t: cmd_ready_o = 0, expected 1", $time);
                        errors++;
                    end
                    busy_cmd   = 1'b0;
                    after_done = 1'b0;
                    row_done   = 1'b1;
                end else begin
                    assert (!cmd_ready_o) else begin
                        $display("** Error at %0t: cmd_ready_o = 1, expected 0", $time);
                        errors++;
                    end
                    after_done = done_o;
                end
            end
            if (cmd_valid_i && cmd_ready_o) begin
                busy_cmd     = 1'b1;
                cmd_accepted = 1'b1;
            end
        end
    end

    task automatic check_reset();
        int unsigned err_before;
        err_before = errors;
        assert (cmd_ready_o === 1'b1) else begin
            $display("** Error at %0t: cmd_ready_o = %b, expected 1", $time, cmd_ready_o);
            errors++;
        end
        assert (res_valid_o === 1'b0 && done_o === 1'b0 && mem_req_o === 1'b0) else begin
            $display("** Error at %0t: res_valid_o/done_o/mem_req_o = %b%b%b, expected 000",
                     $time, res_valid_o, done_o, mem_req_o);
            errors++;
        end
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test reset: %s", (errors == err_before) ? "pass" : "FAIL");
    endtask

    task automatic apply_row(input int t);
        int unsigned err_before, passes;
        test_row_t   row;
        row        = tests[t];
        err_before = errors;
        passes     = (row.mode == sfm_pkg::MODE_FULL) ? 2 : 1;
        run_model(row);
        if (exp_q.size() != row.n_res) begin
            $display("Test %0d: table lists %0d results but the model gives %0d",
                     t, row.n_res, exp_q.size());
            errors++;
        end
        @(negedge clk_i);
        req_cnt      = 0;
        done_cnt     = 0;
        res_idx      = 0;
        cmd_accepted = 1'b0;
        row_done     = 1'b0;
        cur_base     = row.base;
        cur_len      = row.len;
        cmd_i        = '{mode: row.mode, last: row.last, slot: row.slot,
                         base: row.base, len: row.len};
        cmd_valid_i  = 1'b1;
        @(negedge clk_i);
        while (!cmd_accepted) begin
            @(negedge clk_i);
        end
        cmd_valid_i = 1'b0;
        while (!row_done) begin
            @(negedge clk_i);
        end
        // Idle cycles catch stray results or done pulses
        repeat (4) @(negedge clk_i);
        assert (req_cnt == passes * row.len) else begin
            $display("** Error at %0t: memory request count = %0d, expected %0d",
                     $time, req_cnt, passes * row.len);
            errors++;
        end
        assert (done_cnt == 1) else begin
            $display("** Error at %0t: done_o pulse count = %0d, expected 1", $time, done_cnt);
            errors++;
        end
        assert (res_idx == exp_q.size()) else begin
            $display("** Error at %0t: result count = %0d, expected %0d",
                     $time, res_idx, exp_q.size());
            errors++;
        end
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test %0d %-4s slot %0d base %h len %0d: %s", t, mode_name(row.mode),
                 row.slot, row.base, row.len, (errors == err_before) ? "pass" : "FAIL");
    endtask

    initial begin
        int          t, a;
        int unsigned r;
        rst_ni      = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        mem_rdata_i = '0;
        for (t = 0; t < N_TESTS; t++) begin
            cycle_limit += 40 * tests[t].len + 100;
        end
        // Scores between -40 and 40
        for (a = 0; a < 256; a++) begin
            draw_bits(7, r);
            mem[a] = 16'(int'(r % 81) - 40);
        end
        for (a = 0; a < 16; a++) begin
            m_valid[a] = 1'b0;
            m_max[a]   = 0;
            m_den[a]   = 0;
        end
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_reset();
        for (t = 0; t < N_TESTS; t++) begin
            apply_row(t);
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 N_TESTS + 1, N_TESTS + 1 - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sfm.f
logic/sfm_pkg.sv
logic/sfm_serial_div.sv
logic/sfm_ctrl.sv
logic/sfm_fetch.sv
logic/sfm_credit_fifo.sv
logic/sfm_datapath.sv
logic/sfm_top.sv
verif/sfm_tb.sv

// File: Bender.yml
package:
  name: sfm

sources:
  - logic/sfm_pkg.sv
  - logic/sfm_serial_div.sv
  - logic/sfm_ctrl.sv
  - logic/sfm_fetch.sv
  - logic/sfm_credit_fifo.sv
  - logic/sfm_datapath.sv
  - logic/sfm_top.sv
  - target: test
    files:
      - verif/sfm_tb.sv
